/* ex_alu.sv */
/*
 * Integer ALU of the EX stage.
 * Covers OP and OP_IMM forms, LUI through PASS_B and AUIPC as an ADD on the PC.
 */
module ex_alu (
  input  ex_pkg::ex_op_t    op,
  output ex_pkg::unit_res_t res
);

  localparam int XLEN = riscv_isa_pkg::XLEN;

  logic [4:0] shamt;
  logic       lt;
  logic       ltu;

  // Shift amount from the low bits of opB
  assign shamt = op.opb[4:0];

  // Signed and unsigned compares
  assign lt  = $signed(op.opa) < $signed(op.opb);
  assign ltu = op.opa < op.opb;

  always_comb
  begin
    res.valid = op.valid && (op.unit == ex_pkg::UNIT_ALU);
    case (op.alu_op)
      ex_pkg::ALU_ADD:    res.value = op.opa + op.opb;
      ex_pkg::ALU_SUB:    res.value = op.opa - op.opb;
      ex_pkg::ALU_SLL:    res.value = op.opa << shamt;
      ex_pkg::ALU_SLT:    res.value = {{(XLEN-1){1'b0}}, lt};
      ex_pkg::ALU_SLTU:   res.value = {{(XLEN-1){1'b0}}, ltu};
      ex_pkg::ALU_XOR:    res.value = op.opa ^ op.opb;
      ex_pkg::ALU_SRL:    res.value = op.opa >> shamt;
      // Arithmetic shift keeps the sign
      ex_pkg::ALU_SRA:    res.value = $unsigned($signed(op.opa) >>> shamt);
      ex_pkg::ALU_OR:     res.value = op.opa | op.opb;
      ex_pkg::ALU_AND:    res.value = op.opa & op.opb;
      ex_pkg::ALU_PASS_B: res.value = op.opb;
      default:            res.value = '0;
    endcase
  end

endmodule

/* ex_branch.sv */
/*
 * Branch unit of the EX stage.
 * Evaluates branch conditions, forms the jump target and link value,
 * and requests a flush for every taken, aligned control transfer.
 */
module ex_branch (
  input  ex_pkg::ex_op_t  op,
  output ex_pkg::br_res_t res
);

  localparam int XLEN = riscv_isa_pkg::XLEN;

  logic            eq;
  logic            lt;
  logic            ltu;
  logic            taken;
  logic [XLEN-1:0] target;

  // Condition flags on rs1 and rs2
  assign eq  = op.opa == op.opb;
  assign lt  = $signed(op.opa) < $signed(op.opb);
  assign ltu = op.opa < op.opb;

  always_comb
  begin
    case (op.br_op)
      ex_pkg::BR_BEQ:  taken = eq;
      ex_pkg::BR_BNE:  taken = ~eq;
      ex_pkg::BR_BLT:  taken = lt;
      ex_pkg::BR_BGE:  taken = ~lt;
      ex_pkg::BR_BLTU: taken = ltu;
      ex_pkg::BR_BGEU: taken = ~ltu;
      ex_pkg::BR_JAL:  taken = 1'b1;
      ex_pkg::BR_JALR: taken = 1'b1;
      default:         taken = 1'b0;
    endcase
  end

  // JALR is register relative with bit 0 cleared
  assign target = (op.br_op == ex_pkg::BR_JALR) ? ((op.opa + op.imm) & ~XLEN'(1))
                                                : (op.pc + op.imm);

  always_comb
  begin
    res.valid      = op.valid && (op.unit == ex_pkg::UNIT_BRANCH);
    res.link       = op.pc + XLEN'(4);
    res.nxt_pc     = target;
    // Without RVC a target must be word aligned
    res.misaligned = res.valid && taken && (target[1:0] != 2'b00);
    res.flush      = res.valid && taken && (target[1:0] == 2'b00);
  end

endmodule

/* ex_decode.sv */
/*
 * Instruction decode and operand select for the EX stage.
 * Maps the RV32 encoding onto the unit opcodes and applies the EX/WB bypass priority.
 */
module ex_decode (
  input  logic [riscv_isa_pkg::XLEN-1:0] id_pc,
  input  logic [31:0]                    id_instr,
  input  logic                           id_bubble,
  input  logic                           id_bypex_opa,
  input  logic                           id_bypex_opb,
  input  logic                           id_bypwb_opa,
  input  logic                           id_bypwb_opb,
  input  logic [riscv_isa_pkg::XLEN-1:0] rf_srcv1,
  input  logic [riscv_isa_pkg::XLEN-1:0] rf_srcv2,
  input  logic [riscv_isa_pkg::XLEN-1:0] wb_r,
  input  logic [riscv_isa_pkg::XLEN-1:0] ex_r,
  output ex_pkg::ex_op_t                 op
);

  localparam int XLEN = riscv_isa_pkg::XLEN;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic            bad;

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic ex_pkg::alu_op_t alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      riscv_isa_pkg::F3_ADD_SUB: return alt ? ex_pkg::ALU_SUB : ex_pkg::ALU_ADD;
      riscv_isa_pkg::F3_SLL:     return ex_pkg::ALU_SLL;
      riscv_isa_pkg::F3_SLT:     return ex_pkg::ALU_SLT;
      riscv_isa_pkg::F3_SLTU:    return ex_pkg::ALU_SLTU;
      riscv_isa_pkg::F3_XOR:     return ex_pkg::ALU_XOR;
      riscv_isa_pkg::F3_SRL_SRA: return alt ? ex_pkg::ALU_SRA : ex_pkg::ALU_SRL;
      riscv_isa_pkg::F3_OR:      return ex_pkg::ALU_OR;
      default:                   return ex_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = id_instr[6:0];
  assign funct3 = id_instr[14:12];
  assign funct7 = id_instr[31:25];

  // Immediate formats
  assign imm_i = {{20{id_instr[31]}}, id_instr[31:20]};
  assign imm_u = {id_instr[31:12], 12'b0};
  assign imm_b = {{19{id_instr[31]}}, id_instr[31], id_instr[7], id_instr[30:25],
                  id_instr[11:8], 1'b0};
  assign imm_j = {{11{id_instr[31]}}, id_instr[31], id_instr[19:12], id_instr[20],
                  id_instr[30:21], 1'b0};

  // Bypass, EX first, then WB, then register file
  assign rs1_val = id_bypex_opa ? ex_r : (id_bypwb_opa ? wb_r : rf_srcv1);
  assign rs2_val = id_bypex_opb ? ex_r : (id_bypwb_opb ? wb_r : rf_srcv2);

  always_comb
  begin
    // Defaults describe an OP instruction
    op.valid  = ~id_bubble;
    op.unit   = ex_pkg::UNIT_ALU;
    op.alu_op = alu_from_f3(funct3, funct7 == riscv_isa_pkg::F7_ALT);
    op.br_op  = ex_pkg::BR_BEQ;
    op.mul_op = ex_pkg::mul_op_t'(funct3[1:0]);
    op.opa    = rs1_val;
    op.opb    = rs2_val;
    op.imm    = imm_i;
    op.pc     = id_pc;
    bad       = 1'b0;

    case (opcode)
      riscv_isa_pkg::OPC_OP:
      begin
        if (funct7 == riscv_isa_pkg::F7_MULDIV)
        begin
          // Divide encodings are not supported
          op.unit = ex_pkg::UNIT_MUL;
          bad     = funct3[2];
        end
        else if (funct7 == riscv_isa_pkg::F7_ALT)
          bad = (funct3 != riscv_isa_pkg::F3_ADD_SUB) && (funct3 != riscv_isa_pkg::F3_SRL_SRA);
        else
          bad = (funct7 != riscv_isa_pkg::F7_BASE);
      end
      riscv_isa_pkg::OPC_OP_IMM:
      begin
        // Only shifts look at funct7, ADDI keeps its sign bit
        op.alu_op = alu_from_f3(funct3, (funct3 == riscv_isa_pkg::F3_SRL_SRA) &&
                                        (funct7 == riscv_isa_pkg::F7_ALT));
        op.opb    = imm_i;
        if (funct3 == riscv_isa_pkg::F3_SLL)
          bad = (funct7 != riscv_isa_pkg::F7_BASE);
        else if (funct3 == riscv_isa_pkg::F3_SRL_SRA)
          bad = (funct7 != riscv_isa_pkg::F7_BASE) && (funct7 != riscv_isa_pkg::F7_ALT);
      end
      riscv_isa_pkg::OPC_LUI:
      begin
        op.alu_op = ex_pkg::ALU_PASS_B;
        op.opb    = imm_u;
      end
      riscv_isa_pkg::OPC_AUIPC:
      begin
        op.alu_op = ex_pkg::ALU_ADD;
        op.opa    = id_pc;
        op.opb    = imm_u;
      end
      riscv_isa_pkg::OPC_JAL:
      begin
        op.unit  = ex_pkg::UNIT_BRANCH;
        op.br_op = ex_pkg::BR_JAL;
        op.opa   = id_pc;
        op.opb   = imm_j;
        op.imm   = imm_j;
      end
      riscv_isa_pkg::OPC_JALR:
      begin
        op.unit  = ex_pkg::UNIT_BRANCH;
        op.br_op = ex_pkg::BR_JALR;
        op.opb   = imm_i;
        bad      = (funct3 != 3'd0);
      end
      riscv_isa_pkg::OPC_BRANCH:
      begin
        // Compare rs1 with rs2, the target comes from the PC field
        op.unit = ex_pkg::UNIT_BRANCH;
        op.imm  = imm_b;
        case (funct3)
          riscv_isa_pkg::F3_BEQ:  op.br_op = ex_pkg::BR_BEQ;
          riscv_isa_pkg::F3_BNE:  op.br_op = ex_pkg::BR_BNE;
          riscv_isa_pkg::F3_BLT:  op.br_op = ex_pkg::BR_BLT;
          riscv_isa_pkg::F3_BGE:  op.br_op = ex_pkg::BR_BGE;
          riscv_isa_pkg::F3_BLTU: op.br_op = ex_pkg::BR_BLTU;
          riscv_isa_pkg::F3_BGEU: op.br_op = ex_pkg::BR_BGEU;
          default:                bad      = 1'b1;
        endcase
      end
      default:
        bad = 1'b1;
    endcase

    // Illegal encodings run as a harmless ALU op
    if (bad)
      op.unit = ex_pkg::UNIT_ALU;
    op.illegal = op.valid & bad;
  end

endmodule

/* ex_mul.sv */
/*
 * Multi-cycle multiplier for MUL, MULH, MULHSU and MULHU.
 * Stalls the stage for MUL_LATENCY cycles, then presents the selected product half.
 */
module ex_mul #(
  parameter int MUL_LATENCY = 2
) (
  input  logic              clk,
  input  logic              rstn,
  input  ex_pkg::ex_op_t    op,
  output ex_pkg::unit_res_t res,
  output logic              stall
);

  localparam int XLEN = riscv_isa_pkg::XLEN;
  localparam int CW   = $clog2(MUL_LATENCY + 1);

  logic                     start;
  logic                     last;
  logic [CW-1:0]            cnt;
  logic                     a_signed;
  logic                     b_signed;
  logic signed [XLEN:0]     a_ext;
  logic signed [XLEN:0]     b_ext;
  logic signed [2*XLEN+1:0] prod;

  ////////////////////////////////////////////////////
  // Stall control

  assign start = op.valid && (op.unit == ex_pkg::UNIT_MUL);

  // Counter at 1 marks the cycle the product is taken
  assign last  = (cnt == CW'(1));
  assign stall = start && !last;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      cnt <= '0;
    else if (cnt != '0)
      cnt <= start ? cnt - 1'b1 : '0;
    else if (start)
      cnt <= CW'(MUL_LATENCY);
  end

  ////////////////////////////////////////////////////
  // Product

  // Operand signedness per variant, MUL low half is sign independent
  always_comb
  begin
    case (op.mul_op)
      ex_pkg::MUL_MULHSU: {a_signed, b_signed} = 2'b10;
      ex_pkg::MUL_MULHU:  {a_signed, b_signed} = 2'b00;
      default:            {a_signed, b_signed} = 2'b11;
    endcase
  end

  // One 33x33 signed multiply covers all variants
  assign a_ext = $signed({a_signed & op.opa[XLEN-1], op.opa});
  assign b_ext = $signed({b_signed & op.opb[XLEN-1], op.opb});
  assign prod  = a_ext * b_ext;

  always_comb
  begin
    res.valid = start && last;
    if (op.mul_op == ex_pkg::MUL_MUL)
      res.value = prod[XLEN-1:0];
    else
      res.value = prod[2*XLEN-1:XLEN];
  end

endmodule

/* ex_pkg.sv */
/*
 * Internal types of the EX stage.
 * The decoded instruction and the per-unit results travel between blocks as these structs.
 */
package ex_pkg;

  // Unit that owns the instruction
  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_BRANCH,
    UNIT_MUL
  } unit_t;

  // ALU operations, PASS_B serves LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  // Branch unit operations
  typedef enum logic [2:0] {
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_JAL,
    BR_JALR
  } br_op_t;

  // Multiplier operations
  typedef enum logic [1:0] {
    MUL_MUL,
    MUL_MULH,
    MUL_MULHSU,
    MUL_MULHU
  } mul_op_t;

  ////////////////////////////////////////////////////
  // Decoded instruction from ex_decode
  typedef struct packed {
    logic                           valid;
    unit_t                          unit;
    alu_op_t                        alu_op;
    br_op_t                         br_op;
    mul_op_t                        mul_op;
    logic [riscv_isa_pkg::XLEN-1:0] opa;
    logic [riscv_isa_pkg::XLEN-1:0] opb;
    logic [riscv_isa_pkg::XLEN-1:0] imm;
    logic [riscv_isa_pkg::XLEN-1:0] pc;
    logic                           illegal;
  } ex_op_t;

  // ALU or multiplier result
  typedef struct packed {
    logic                           valid;
    logic [riscv_isa_pkg::XLEN-1:0] value;
  } unit_res_t;

  // Branch outcome
  typedef struct packed {
    logic                           valid;
    logic [riscv_isa_pkg::XLEN-1:0] link;
    logic                           flush;
    logic [riscv_isa_pkg::XLEN-1:0] nxt_pc;
    logic                           misaligned;
  } br_res_t;

endpackage

/* ex_result.sv */
/*
 * Output register of the EX stage.
 * Picks the unit result, merges exception causes and holds everything while stalled.
 */
module ex_result #(
  parameter logic [riscv_isa_pkg::XLEN-1:0] PC_INIT = 'h200
) (
  input  logic                                clk,
  input  logic                                rstn,
  input  ex_pkg::ex_op_t                      op,
  input  logic                                id_bubble,
  input  logic [31:0]                         id_instr,
  input  logic [riscv_isa_pkg::exc_size-1:0]  id_exception,
  input  ex_pkg::unit_res_t                   alu_res,
  input  ex_pkg::br_res_t                     br_res,
  input  ex_pkg::unit_res_t                   mul_res,
  input  logic                                stall,
  output logic [riscv_isa_pkg::XLEN-1:0]      ex_pc,
  output logic [31:0]                         ex_instr,
  output logic                                ex_bubble,
  output logic [riscv_isa_pkg::XLEN-1:0]      ex_r,
  output logic [riscv_isa_pkg::exc_size-1:0]  ex_exception,
  output logic                                bu_flush,
  output logic [riscv_isa_pkg::XLEN-1:0]      bu_nxt_pc
);

  logic [riscv_isa_pkg::XLEN-1:0]     r_d;
  logic [riscv_isa_pkg::exc_size-1:0] exc_d;
  logic                               flush_d;

  // Result select, multiplier then link value then ALU
  always_comb
  begin
    if (mul_res.valid)
      r_d = mul_res.value;
    else if (br_res.valid)
      r_d = br_res.link;
    else if (alu_res.valid)
      r_d = alu_res.value;
    else
      r_d = '0;
  end

  // A bubble relays only the decode exceptions
  always_comb
  begin
    exc_d = id_exception;
    if (!id_bubble)
    begin
      exc_d[riscv_isa_pkg::cause_illegal_instr]    |= op.illegal;
      exc_d[riscv_isa_pkg::cause_misaligned_instr] |= br_res.misaligned;
    end
  end

  assign flush_d = br_res.flush && !id_bubble && (exc_d == '0);

  ////////////////////////////////////////////////////
  // Pipeline registers

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      ex_pc        <= PC_INIT;
      ex_instr     <= riscv_isa_pkg::instr_nop;
      ex_bubble    <= 1'b1;
      ex_exception <= '0;
      bu_flush     <= 1'b0;
    end
    else if (!stall)
    begin
      ex_pc        <= op.pc;
      ex_instr     <= id_instr;
      ex_bubble    <= id_bubble;
      ex_exception <= exc_d;
      bu_flush     <= flush_d;
    end
    else
      // Flush is a single cycle pulse
      bu_flush <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
    begin
      ex_r      <= r_d;
      bu_nxt_pc <= br_res.nxt_pc;
    end
  end

endmodule

/* ex_stage_checker.sv */
/*
 * Concurrent assertions on the EX stage outputs.
 * Bound into riscv_ex_stage from the testbench top, which reads the failure count.
 */
module ex_stage_checker #(
  parameter int MUL_LATENCY = 2
) (
  input logic                               clk,
  input logic                               rstn,
  input logic                               ex_stall,
  input logic                               bu_flush,
  input logic                               ex_bubble,
  input logic [riscv_isa_pkg::exc_size-1:0] ex_exception
);

  // Number of assertion failures so far
  int failures = 0;

  // Stall never outlasts the multiplier latency
  stall_length: assert property (@(posedge clk) disable iff (!rstn)
    ex_stall [*MUL_LATENCY] |=> !ex_stall)
    else
    begin
      failures++;
      $error("ex_stall high for more than %0d cycles", MUL_LATENCY);
    end

  // A bubble never redirects fetch
  no_bubble_flush: assert property (@(posedge clk) disable iff (!rstn)
    !(bu_flush && ex_bubble))
    else
    begin
      failures++;
      $error("bu_flush high together with ex_bubble");
    end

  // Quiet outputs right after reset release
  reset_quiet: assert property (@(posedge clk)
    $rose(rstn) |-> (!ex_stall && !bu_flush && (ex_exception == '0)))
    else
    begin
      failures++;
      $error("stall, flush or exception set after reset");
    end

endmodule

/* ex_stimulus.txt */
// instr pc rs1 rs2 wb_r flags id_exc | exp_r exp_flush exp_nxt_pc exp_exc
// flags digits: check_r bypex_a bypex_b bypwb_a bypwb_b bubble
002081B3 00000100 00000005 00000007 00000000 00100000 000 0000000C 0 00000000 000
402081B3 00000104 00000005 00000007 00000000 00100000 000 FFFFFFFE 0 00000000 000
0020A1B3 00000108 FFFFFFFF 00000001 00000000 00100000 000 00000001 0 00000000 000
0020B1B3 0000010C FFFFFFFF 00000001 00000000 00100000 000 00000000 0 00000000 000
0020C1B3 00000110 F0F0F0F0 0FF00FF0 00000000 00100000 000 FF00FF00 0 00000000 000
4020D1B3 00000114 80000010 00000004 00000000 00100000 000 F8000001 0 00000000 000
FFB08193 00000118 00000003 00000000 00000000 00100000 000 FFFFFFFE 0 00000000 000
4040D193 0000011C 80000000 00000000 00000000 00100000 000 F8000000 0 00000000 000
123451B7 00000120 00000000 00000000 00000000 00100000 000 12345000 0 00000000 000
00001197 00000124 00000000 00000000 00000000 00100000 000 00001124 0 00000000 000
002081B3 00000128 00000000 00000001 00000999 00110100 000 00001125 0 00000000 000
002081B3 0000012C 00000002 00000000 00000040 00100010 000 00000042 0 00000000 000
002081B3 00000130 00000000 00000000 00000000 00111000 000 00000084 0 00000000 000
00208863 00000200 00000009 00000009 00000000 00000000 000 00000000 1 00000210 000
00209863 00000210 00000009 00000009 00000000 00000000 000 00000000 0 00000000 000
FE20CCE3 00000300 FFFFFFF0 00000001 00000000 00000000 000 00000000 1 000002F8 000
0020F863 00000310 00000001 FFFFFFFF 00000000 00000000 000 00000000 0 00000000 000
100000EF 00000400 00000000 00000000 00000000 00100000 000 00000404 1 00000500 000
008280E7 00000404 00001001 00000000 00000000 00100000 000 00000408 1 00001008 000
006280E7 00000408 00001000 00000000 00000000 00100000 000 0000040C 0 00000000 001
022081B3 00000500 FFFFFFFE 00000003 00000000 00100000 000 FFFFFFFA 0 00000000 000
022091B3 00000504 80000000 80000000 00000000 00100000 000 40000000 0 00000000 000
0220A1B3 00000508 FFFFFFFF FFFFFFFF 00000000 00100000 000 FFFFFFFF 0 00000000 000
0220B1B3 0000050C FFFFFFFF FFFFFFFF 00000000 00100000 000 FFFFFFFE 0 00000000 000
0000007F 00000600 00000000 00000000 00000000 00000000 000 00000000 0 00000000 004
0220C1B3 00000604 00000006 00000003 00000000 00000000 000 00000000 0 00000000 004
00208863 00000608 00000009 00000009 00000000 00000001 010 00000000 0 00000000 010
002081B3 0000060C 00000005 00000007 00000000 00100000 100 0000000C 0 00000000 100

/* files.f */
riscv_isa_pkg.sv
ex_pkg.sv
ex_decode.sv
ex_alu.sv
ex_branch.sv
ex_mul.sv
ex_result.sv
riscv_ex_stage.sv
tb_clock_gen.sv
ex_stage_checker.sv
tb_ex_stage.sv

/* riscv_ex_stage.sv */
/*
 * Execute stage of an in-order RV32 integer pipeline.
 * Decode, ALU, branch unit, multiplier and result register wired together,
 * with ex_r looped back for the EX bypass.
 */
module riscv_ex_stage #(
  parameter logic [riscv_isa_pkg::XLEN-1:0] PC_INIT     = 'h200,
  parameter int                             MUL_LATENCY = 2
) (
  input  logic                               clk,
  input  logic                               rstn,

  // From decode
  input  logic [riscv_isa_pkg::XLEN-1:0]     id_pc,
  input  logic [31:0]                        id_instr,
  input  logic                               id_bubble,
  input  logic [riscv_isa_pkg::exc_size-1:0] id_exception,
  input  logic                               id_bypex_opa,
  input  logic                               id_bypex_opb,
  input  logic                               id_bypwb_opa,
  input  logic                               id_bypwb_opb,

  // Register file and WB bypass
  input  logic [riscv_isa_pkg::XLEN-1:0]     rf_srcv1,
  input  logic [riscv_isa_pkg::XLEN-1:0]     rf_srcv2,
  input  logic [riscv_isa_pkg::XLEN-1:0]     wb_r,

  // To memory/writeback
  output logic [riscv_isa_pkg::XLEN-1:0]     ex_pc,
  output logic [31:0]                        ex_instr,
  output logic                               ex_bubble,
  output logic [riscv_isa_pkg::XLEN-1:0]     ex_r,
  output logic [riscv_isa_pkg::exc_size-1:0] ex_exception,

  // Back-pressure and redirect
  output logic                               ex_stall,
  output logic                               bu_flush,
  output logic [riscv_isa_pkg::XLEN-1:0]     bu_nxt_pc
);

  ex_pkg::ex_op_t    op;
  ex_pkg::unit_res_t alu_res;
  ex_pkg::br_res_t   br_res;
  ex_pkg::unit_res_t mul_res;

  ////////////////////////////////////////////////////
  // Decode and operand select

  ex_decode u_decode (
    .id_pc        (id_pc),
    .id_instr     (id_instr),
    .id_bubble    (id_bubble),
    .id_bypex_opa (id_bypex_opa),
    .id_bypex_opb (id_bypex_opb),
    .id_bypwb_opa (id_bypwb_opa),
    .id_bypwb_opb (id_bypwb_opb),
    .rf_srcv1     (rf_srcv1),
    .rf_srcv2     (rf_srcv2),
    .wb_r         (wb_r),
    .ex_r         (ex_r),
    .op           (op)
  );

  ////////////////////////////////////////////////////
  // Execution units

  ex_alu u_alu (
    .op  (op),
    .res (alu_res)
  );

  ex_branch u_branch (
    .op  (op),
    .res (br_res)
  );

  // Only the multiplier stalls
  ex_mul #(
    .MUL_LATENCY (MUL_LATENCY)
  ) u_mul (
    .clk   (clk),
    .rstn  (rstn),
    .op    (op),
    .res   (mul_res),
    .stall (ex_stall)
  );

  // Result merge and output registers
  ex_result #(
    .PC_INIT (PC_INIT)
  ) u_result (
    .clk          (clk),
    .rstn         (rstn),
    .op           (op),
    .id_bubble    (id_bubble),
    .id_instr     (id_instr),
    .id_exception (id_exception),
    .alu_res      (alu_res),
    .br_res       (br_res),
    .mul_res      (mul_res),
    .stall        (ex_stall),
    .ex_pc        (ex_pc),
    .ex_instr     (ex_instr),
    .ex_bubble    (ex_bubble),
    .ex_r         (ex_r),
    .ex_exception (ex_exception),
    .bu_flush     (bu_flush),
    .bu_nxt_pc    (bu_nxt_pc)
  );

endmodule

/* riscv_isa_pkg.sv */
/*
 * RV32 base encodings shared by every block of the EX stage.
 * Opcode, funct3 and funct7 fields plus the exception cause bit indexes.
 */
package riscv_isa_pkg;

  // Data width of the integer datapath
  parameter int XLEN = 32;

  // Major opcodes handled by this stage
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_t;

  // funct3 for OP and OP_IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'd0,
    F3_SLL     = 3'd1,
    F3_SLT     = 3'd2,
    F3_SLTU    = 3'd3,
    F3_XOR     = 3'd4,
    F3_SRL_SRA = 3'd5,
    F3_OR      = 3'd6,
    F3_AND     = 3'd7
  } funct3_alu_t;

  // funct3 for conditional branches, 2 and 3 are reserved
  typedef enum logic [2:0] {
    F3_BEQ  = 3'd0,
    F3_BNE  = 3'd1,
    F3_BLT  = 3'd4,
    F3_BGE  = 3'd5,
    F3_BLTU = 3'd6,
    F3_BGEU = 3'd7
  } funct3_br_t;

  // funct3 for the M extension multiplies
  typedef enum logic [2:0] {
    F3_MUL    = 3'd0,
    F3_MULH   = 3'd1,
    F3_MULHSU = 3'd2,
    F3_MULHU  = 3'd3
  } funct3_mul_t;

  // funct7 variants
  typedef enum logic [6:0] {
    F7_BASE   = 7'b0000000,
    F7_ALT    = 7'b0100000,
    F7_MULDIV = 7'b0000001
  } funct7_t;

  // ADDI x0,x0,0
  localparam logic [31:0] instr_nop = 32'h0000_0013;

  // Exception vector, one bit per cause
  parameter int exc_size              = 12;
  parameter int cause_misaligned_instr = 0;
  parameter int cause_illegal_instr    = 2;

endpackage

/* tb_clock_gen.sv */
/*
 * Testbench clock and reset source.
 * Period of 8, rstn held low for the first 3 clock cycles.
 */
module tb_clock_gen (
  output logic clk,
  output logic rstn
);

  // Free running clock
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset released on a falling edge, away from the sampling edge
  initial
  begin
    rstn = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

/* tb_ex_stage.sv */
/*
 * Testbench for the EX stage.
 * Reads vectors from ex_stimulus.txt, drives them on the falling edge and
 * compares the registered outputs one cycle after the stall has ended.
 */
module tb_ex_stage;

  localparam logic [31:0] PC_INIT     = 32'h200;
  localparam int          MUL_LATENCY = 2;
  localparam int          NVEC        = 28;
  localparam int          WPV         = 11;
  localparam int          TIMEOUT     = 20;
  localparam int          EXC_W       = riscv_isa_pkg::exc_size;

  logic             clk;
  logic             rstn;
  logic [31:0]      id_pc;
  logic [31:0]      id_instr;
  logic             id_bubble;
  logic [EXC_W-1:0] id_exception;
  logic             id_bypex_opa;
  logic             id_bypex_opb;
  logic             id_bypwb_opa;
  logic             id_bypwb_opb;
  logic [31:0]      rf_srcv1;
  logic [31:0]      rf_srcv2;
  logic [31:0]      wb_r;
  logic [31:0]      ex_pc;
  logic [31:0]      ex_instr;
  logic             ex_bubble;
  logic [31:0]      ex_r;
  logic [EXC_W-1:0] ex_exception;
  logic             ex_stall;
  logic             bu_flush;
  logic [31:0]      bu_nxt_pc;

  // Eleven words per vector
  logic [31:0] vec_mem [0:NVEC*WPV-1];

  int seed;
  int errors;
  int test_errors;
  int tests_passed;
  int tests_failed;
  bit timed_out;

  tb_clock_gen u_clock (
    .clk  (clk),
    .rstn (rstn)
  );

  riscv_ex_stage #(
    .PC_INIT     (PC_INIT),
    .MUL_LATENCY (MUL_LATENCY)
  ) UUT (
    .clk          (clk),
    .rstn         (rstn),
    .id_pc        (id_pc),
    .id_instr     (id_instr),
    .id_bubble    (id_bubble),
    .id_exception (id_exception),
    .id_bypex_opa (id_bypex_opa),
    .id_bypex_opb (id_bypex_opb),
    .id_bypwb_opa (id_bypwb_opa),
    .id_bypwb_opb (id_bypwb_opb),
    .rf_srcv1     (rf_srcv1),
    .rf_srcv2     (rf_srcv2),
    .wb_r         (wb_r),
    .ex_pc        (ex_pc),
    .ex_instr     (ex_instr),
    .ex_bubble    (ex_bubble),
    .ex_r         (ex_r),
    .ex_exception (ex_exception),
    .ex_stall     (ex_stall),
    .bu_flush     (bu_flush),
    .bu_nxt_pc    (bu_nxt_pc)
  );

  bind riscv_ex_stage ex_stage_checker #(
    .MUL_LATENCY (MUL_LATENCY)
  ) u_checker (
    .clk          (clk),
    .rstn         (rstn),
    .ex_stall     (ex_stall),
    .bu_flush     (bu_flush),
    .ex_bubble    (ex_bubble),
    .ex_exception (ex_exception)
  );

  ////////////////////////////////////////////////////
  // Helpers

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      test_errors++;
      $display("[FAIL] t=%0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  // M extension multiply: OP with funct7 1 and funct3 below 4
  function automatic bit is_multiply(input logic [31:0] instr);
    return (instr[6:0] == 7'b0110011) && (instr[31:25] == 7'b0000001) && !instr[14];
  endfunction

  task automatic report_test(input string name);
    if (test_errors == 0)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  // Reset state of the registered outputs
  task automatic check_reset_state(input string name);
    check_value("ex_pc", ex_pc, PC_INIT);
    check_value("ex_instr", ex_instr, 32'h0000_0013);
    check_value("ex_bubble", ex_bubble, 1'b1);
    check_value("bu_flush", bu_flush, 1'b0);
    check_value("ex_stall", ex_stall, 1'b0);
    check_value("ex_exception", ex_exception, '0);
    report_test(name);
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (!rstn && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (!rstn)
    begin
      timed_out = 1'b1;
      $display("Timeout: reset was never released");
    end
  endtask

  ////////////////////////////////////////////////////
  // One vector, driven at a falling edge

  task automatic run_vector(input int v);
    logic [31:0] instr;
    logic [31:0] s1;
    logic [31:0] s2;
    logic [31:0] flags;
    logic [31:0] exp_r;
    logic [31:0] exp_nxt;
    int          base;
    int          stall_cycles;
    base  = v * WPV;
    instr = vec_mem[base];
    s1    = vec_mem[base+2];
    s2    = vec_mem[base+3];
    flags = vec_mem[base+5];
    exp_r   = vec_mem[base+7];
    exp_nxt = vec_mem[base+9];
    // Bypassed register values are filler
    if (flags[16] || flags[8])
      s1 = $random(seed);
    if (flags[12] || flags[4])
      s2 = $random(seed);
    id_instr     = instr;
    id_pc        = vec_mem[base+1];
    rf_srcv1     = s1;
    rf_srcv2     = s2;
    wb_r         = vec_mem[base+4];
    id_bypex_opa = flags[16];
    id_bypex_opb = flags[12];
    id_bypwb_opa = flags[8];
    id_bypwb_opb = flags[4];
    id_bubble    = flags[0];
    id_exception = vec_mem[base+6][EXC_W-1:0];
    #1;
    // Count stall cycles until the stage accepts
    stall_cycles = 0;
    while (ex_stall && stall_cycles < TIMEOUT)
    begin
      stall_cycles++;
      @(negedge clk);
      #1;
    end
    if (ex_stall)
    begin
      timed_out = 1'b1;
      $display("Timeout: ex_stall stayed high in test %0d", v + 1);
    end
    else
    begin
      // Outputs were registered on the rising edge in between
      @(negedge clk);
      check_value("stall cycles", stall_cycles, is_multiply(instr) ? MUL_LATENCY : 0);
      check_value("ex_pc", ex_pc, id_pc);
      check_value("ex_instr", ex_instr, instr);
      check_value("ex_bubble", ex_bubble, flags[0]);
      if (flags[20])
        check_value("ex_r", ex_r, exp_r);
      check_value("bu_flush", bu_flush, vec_mem[base+8][0]);
      if (vec_mem[base+8][0])
        check_value("bu_nxt_pc", bu_nxt_pc, exp_nxt);
      check_value("ex_exception", ex_exception, vec_mem[base+10][EXC_W-1:0]);
      report_test($sformatf("%0d instr %h", v + 1, instr));
    end
  endtask

  ////////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    seed         = 45518;
    errors       = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    // Idle bubbles carry the reset PC
    id_pc        = PC_INIT;
    id_instr     = 32'h0000_0013;
    id_bubble    = 1'b1;
    id_exception = '0;
    id_bypex_opa = 1'b0;
    id_bypex_opb = 1'b0;
    id_bypwb_opa = 1'b0;
    id_bypwb_opb = 1'b0;
    rf_srcv1     = '0;
    rf_srcv2     = '0;
    wb_r         = '0;
    $readmemh("ex_stimulus.txt", vec_mem);

    // Inside reset after the first full clock, then one cycle after release
    @(posedge clk);
    @(negedge clk);
    check_reset_state("reset");
    wait_reset_release();
    if (!timed_out)
    begin
      @(negedge clk);
      check_reset_state("after reset");
    end

    for (int v = 0; v < NVEC && !timed_out; v++)
      run_vector(v);

    errors += UUT.u_checker.failures;
    $display("%0d tests: %0d passed, %0d failed, %0d mismatches",
             tests_passed + tests_failed, tests_passed, tests_failed, errors);
    if (errors == 0 && !timed_out)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
